/* files.f */
verilog/u1_ctrl_pkg.sv
verilog/wb_addr_decode.sv
verilog/misc_ctrl_regs.sv
verilog/settings_bus_16.sv
verilog/setting_reg.sv
verilog/readback_mux_16.sv
verilog/u1_ctrl_top.sv
tests/tb_wb_master.sv
tests/tb_u1_ctrl.sv

/* tests/tb_u1_ctrl.sv */
module tb_u1_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   import u1_ctrl_pkg::*;

   localparam int NUM_SETTINGS = 8;
   localparam int SETTLE_CYCLES = 4;   // change pulse lands two edges after the write

   typedef struct packed {
      logic [2:0]  led;
      logic        sync_b;
      logic        ref_sel;
      logic [7:0]  fpp;
      logic [15:0] test_len;
      logic [7:0]  test_rate;
      logic [3:0]  test_ctrl;
   } outs_t;

   typedef struct {
      string    name;
      bit       is_write;
      wb_addr_t adr;
      wb_data_t wdat;
      wb_data_t rexp;
      logic [2:0] status;   // {status, lock, refmon}
      outs_t    outs;
   } step_t;

   logic wb_clk = 1'b0;
   logic wb_rst;
   wb_addr_t wb_adr;
   wb_data_t wb_dat_w, wb_dat_r;
   logic wb_we, wb_cyc, wb_stb, wb_ack;
   logic cgen_st_status, cgen_st_ld, cgen_st_refmon;
   logic [2:0] led_o;
   logic cgen_sync_b_o, cgen_ref_sel_o;
   logic [7:0] frames_per_packet_o, test_rate_o;
   logic [15:0] test_len_o;
   logic [3:0] test_ctrl_o;
   logic [NUM_SETTINGS-1:0] setting_changed_o, changed_q;

   step_t steps[$];
   outs_t cur;                        // expected outputs while the table is built
   int    pulses[NUM_SETTINGS] = '{default: 0};
   int    exp_pulses[NUM_SETTINGS] = '{default: 0};

   always #4 wb_clk = ~wb_clk;

   u1_ctrl_top #(.NUM_SETTINGS(NUM_SETTINGS)) u1_ctrl_top_i
      (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
       .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
       .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
       .cgen_st_status_i(cgen_st_status), .cgen_st_ld_i(cgen_st_ld),
       .cgen_st_refmon_i(cgen_st_refmon),
       .led_o(led_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
       .frames_per_packet_o(frames_per_packet_o), .test_len_o(test_len_o),
       .test_rate_o(test_rate_o), .test_ctrl_o(test_ctrl_o),
       .setting_changed_o(setting_changed_o));

   tb_wb_master wb_master_i
      (.wb_clk(wb_clk), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_we_o(wb_we),
       .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r));

   task automatic report_mismatch(string name, string what, logic [63:0] exp, logic [63:0] act);
      $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic report_problem(string msg);
      $display("ERROR: %s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // change pulse monitor, one count per rising pulse

   always @(negedge wb_clk)
   begin
      if (wb_rst)
         changed_q <= '0;
      else
      begin
         for (int k = 0; k < NUM_SETTINGS; k++)
         begin
            assert (!(setting_changed_o[k] && changed_q[k]))
               else report_problem($sformatf("change pulse %0d lasted two cycles", k));
            if (setting_changed_o[k] && !changed_q[k])
               pulses[k]++;
         end
         changed_q <= setting_changed_o;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // table helpers

   function automatic wb_addr_t misc_addr(reg_offs_t offs);
      return {4'd0, offs};
   endfunction

   function automatic wb_addr_t setting_addr(int idx, bit hi);
      return {3'b100, 6'(idx), hi, 1'b0};   // index sits in bits 7:2
   endfunction

   function automatic wb_addr_t readback_addr(int idx, bit hi);
      return {4'd7, 1'b0, 4'(idx), hi, 1'b0};
   endfunction

   // register bits 2,1,0 go to pins 2,0,1
   function automatic logic [2:0] led_pins(logic [2:0] r);
      logic [2:0] p;
      p[2] = r[2];
      p[0] = r[1];
      p[1] = r[0];
      return p;
   endfunction

   function automatic outs_t outputs_now();
      return {led_o, cgen_sync_b_o, cgen_ref_sel_o, frames_per_packet_o, test_len_o,
              test_rate_o, test_ctrl_o};
   endfunction

   task automatic add_step(string name, bit is_write, wb_addr_t adr, wb_data_t wdat,
                           wb_data_t rexp, logic [2:0] status);
      step_t s;
      s = '{name, is_write, adr, wdat, rexp, status, cur};
      steps.push_back(s);
   endtask

   task automatic build_table();
      set_data_t  words[16] = '{default: '0};   // unused indices read zero
      logic [2:0] pats[5] = '{3'b100, 3'b010, 3'b001, 3'b111, 3'b000};
      for (int i = 0; i < NUM_SETTINGS; i++)
         words[i] = $urandom();
      cur = '0;
      cur.sync_b  = 1'b1;
      cur.ref_sel = 1'b1;
      add_step("reset_compat", 1'b0, misc_addr(REG_COMPAT), '0, 16'h0004, '0);
      cur.led = led_pins(3'b101);
      add_step("led_write_a", 1'b1, misc_addr(REG_LEDS), 16'h0005, '0, '0);
      add_step("led_read_a", 1'b0, misc_addr(REG_LEDS), '0, 16'h0005, '0);
      cur.led = led_pins(3'b110);
      add_step("led_write_b", 1'b1, misc_addr(REG_LEDS), 16'h0006, '0, '0);
      add_step("led_read_b", 1'b0, misc_addr(REG_LEDS), '0, 16'h0006, '0);
      cur.sync_b  = 1'b0;
      cur.ref_sel = 1'b0;
      add_step("cgen_write_clr", 1'b1, misc_addr(REG_CGEN_CTRL), 16'h0000, '0, '0);
      add_step("cgen_read_clr", 1'b0, misc_addr(REG_CGEN_CTRL), '0, 16'h0000, '0);
      cur.sync_b  = 1'b1;
      cur.ref_sel = 1'b1;
      add_step("cgen_write_set", 1'b1, misc_addr(REG_CGEN_CTRL), 16'h0003, '0, '0);
      add_step("cgen_read_set", 1'b0, misc_addr(REG_CGEN_CTRL), '0, 16'h0003, '0);
      cur.test_len = 16'hA5C3;
      add_step("test_write", 1'b1, misc_addr(REG_TEST), 16'hA5C3, '0, '0);
      add_step("test_read", 1'b0, misc_addr(REG_TEST), '0, 16'hA5C3, '0);
      cur.test_ctrl = 4'hB;
      cur.test_rate = 8'h7E;
      add_step("xfer_write", 1'b1, misc_addr(REG_XFER_RATE), 16'h0B7E, '0, '0);
      add_step("xfer_read", 1'b0, misc_addr(REG_XFER_RATE), '0, 16'hBEEF, '0);
      cur.fpp = 8'h34;
      add_step("framelen_write", 1'b1, misc_addr(REG_RX_FRAMELEN), 16'h1234, '0, '0);
      add_step("framelen_read", 1'b0, misc_addr(REG_RX_FRAMELEN), '0, 16'hBEEF, '0);
      add_step("unmapped_read_2", 1'b0, misc_addr(7'd2), '0, 16'hBEEF, '0);
      add_step("unmapped_read_64", 1'b0, misc_addr(7'd64), '0, 16'hBEEF, '0);
      foreach (pats[p])
         add_step($sformatf("status_%b", pats[p]), 1'b0, misc_addr(REG_CGEN_ST), '0,
                  {13'd0, pats[p]}, pats[p]);
      for (int i = 0; i < NUM_SETTINGS; i++)
      begin
         add_step($sformatf("set%0d_lo_write", i), 1'b1, setting_addr(i, 1'b0),
                  words[i][15:0], '0, '0);
         add_step($sformatf("set%0d_hi_write", i), 1'b1, setting_addr(i, 1'b1),
                  words[i][31:16], '0, '0);
      end
      for (int i = 0; i < 16; i++)
      begin
         add_step($sformatf("rb%0d_lo", i), 1'b0, readback_addr(i, 1'b0), '0, words[i][15:0], '0);
         add_step($sformatf("rb%0d_hi", i), 1'b0, readback_addr(i, 1'b1), '0, words[i][31:16], '0);
      end
      add_step("settings_read", 1'b0, setting_addr(1, 1'b1), '0, 16'h0000, '0);
      // low half alone must not reach the register
      add_step("set0_lone_lo", 1'b1, setting_addr(0, 1'b0), ~words[0][15:0], '0, '0);
      add_step("rb0_lo_kept", 1'b0, readback_addr(0, 1'b0), '0, words[0][15:0], '0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence

   initial
   begin
      step_t    s;
      wb_data_t rdata;
      bit       timed_out;
      int       idx;
      int       seed_ret;
      seed_ret = $urandom(47);
      wb_rst = 1'b1;
      {cgen_st_status, cgen_st_ld, cgen_st_refmon} = 3'b000;
      build_table();
      repeat (4) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      @(negedge wb_clk);
      assert (wb_ack === 1'b0) else report_problem("bus ack is high after reset");
      assert (setting_changed_o === '0) else report_problem("change pulse high after reset");
      foreach (steps[n])
      begin
         s = steps[n];
         @(posedge wb_clk);
         #1;
         {cgen_st_status, cgen_st_ld, cgen_st_refmon} = s.status;
         rdata = '0;
         if (s.is_write)
            wb_master_i.write_word(s.adr, s.wdat, timed_out);
         else
            wb_master_i.read_word(s.adr, rdata, timed_out);
         assert (!timed_out) else report_problem({s.name, ": no bus acknowledge before timeout"});
         if (!s.is_write)
            assert (rdata === s.rexp) else report_mismatch(s.name, "read data", s.rexp, rdata);
         idx = int'(s.adr[7:2]);
         if (s.is_write && s.adr[10:8] == 3'b100 && s.adr[1] && idx < NUM_SETTINGS)
            exp_pulses[idx]++;
         repeat (SETTLE_CYCLES) @(negedge wb_clk);
         assert (outputs_now() === s.outs)
            else report_mismatch(s.name, "outputs", s.outs, outputs_now());
         for (int k = 0; k < NUM_SETTINGS; k++)
            assert (pulses[k] == exp_pulses[k])
               else report_mismatch(s.name, $sformatf("pulses[%0d]", k), exp_pulses[k], pulses[k]);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

/* tests/tb_wb_master.sv */
module tb_wb_master
   (input  logic                  wb_clk,
    output u1_ctrl_pkg::wb_addr_t wb_adr_o,
    output u1_ctrl_pkg::wb_data_t wb_dat_o,
    output logic                  wb_we_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    input  logic                  wb_ack_i,
    input  u1_ctrl_pkg::wb_data_t wb_dat_i);

   timeunit 1ns;
   timeprecision 100ps;

   import u1_ctrl_pkg::*;

   localparam int ACK_TIMEOUT = 32;   // cycles to wait for an ack

   initial
   begin
      wb_adr_o = '0;
      wb_dat_o = '0;
      wb_we_o  = 1'b0;
      wb_cyc_o = 1'b0;
      wb_stb_o = 1'b0;
   end

   // one bus cycle, held until ack is seen at a rising edge
   task automatic run_transfer(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                               output wb_data_t rdat, output bit timed_out);
      int waited;
      waited    = 0;
      timed_out = 1'b0;
      rdat      = '0;
      @(posedge wb_clk);
      #1;
      wb_adr_o = adr;
      wb_dat_o = wdat;
      wb_we_o  = we;
      wb_cyc_o = 1'b1;
      wb_stb_o = 1'b1;
      @(negedge wb_clk);   // ack and data sampled mid cycle
      while (wb_ack_i !== 1'b1 && waited < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      if (wb_ack_i === 1'b1)
         rdat = wb_dat_i;
      else
         timed_out = 1'b1;
      @(posedge wb_clk);   // transfer completes on this edge
      #1;
      wb_cyc_o = 1'b0;
      wb_stb_o = 1'b0;
      wb_we_o  = 1'b0;
   endtask

   task automatic write_word(input wb_addr_t adr, input wb_data_t wdat, output bit timed_out);
      wb_data_t unused;
      run_transfer(adr, 1'b1, wdat, unused, timed_out);
   endtask

   task automatic read_word(input wb_addr_t adr, output wb_data_t rdat, output bit timed_out);
      run_transfer(adr, 1'b0, '0, rdat, timed_out);
   endtask

endmodule

/* verilog/u1_ctrl_top.sv */
module u1_ctrl_top
   #(parameter int NUM_SETTINGS = 8)
   (input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  u1_ctrl_pkg::wb_addr_t  wb_adr_i,
    input  u1_ctrl_pkg::wb_data_t  wb_dat_i,
    input  logic                   wb_we_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    output u1_ctrl_pkg::wb_data_t  wb_dat_o,
    output logic                   wb_ack_o,
    input  logic                   cgen_st_status_i,
    input  logic                   cgen_st_ld_i,
    input  logic                   cgen_st_refmon_i,
    output logic [2:0]             led_o,
    output logic                   cgen_sync_b_o,
    output logic                   cgen_ref_sel_o,
    output logic [7:0]             frames_per_packet_o,
    output logic [15:0]            test_len_o,
    output logic [7:0]             test_rate_o,
    output logic [3:0]             test_ctrl_o,
    output logic [NUM_SETTINGS-1:0] setting_changed_o);

   import u1_ctrl_pkg::*;

   logic      misc_stb, setting_stb, rb_stb;
   logic      misc_ack, setting_ack, rb_ack;
   wb_data_t  misc_dat, rb_dat;

   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   set_data_t [NUM_SETTINGS-1:0] setting_words;   // one slice per setting_reg

   //////////////////////////////////////////////////////////////////////
   // single master decode

   wb_addr_decode wb_addr_decode_i
      (.wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
       .misc_ack_i(misc_ack), .misc_dat_i(misc_dat),
       .setting_ack_i(setting_ack),
       .rb_ack_i(rb_ack), .rb_dat_i(rb_dat),
       .misc_stb_o(misc_stb), .setting_stb_o(setting_stb), .rb_stb_o(rb_stb),
       .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o));

   //////////////////////////////////////////////////////////////////////
   // slave 0, board control and status

   misc_ctrl_regs misc_ctrl_regs_i
      (.wb_clk(wb_clk), .wb_rst(wb_rst),
       .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i[6:0]), .dat_i(wb_dat_i),
       .dat_o(misc_dat), .ack_o(misc_ack),
       .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
       .cgen_st_refmon_i(cgen_st_refmon_i),
       .led_o(led_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
       .frames_per_packet_o(frames_per_packet_o), .test_len_o(test_len_o),
       .test_rate_o(test_rate_o), .test_ctrl_o(test_ctrl_o));

   //////////////////////////////////////////////////////////////////////
   // slave 8/9, settings bus and its registers

   settings_bus_16 settings_bus_16_i
      (.wb_clk(wb_clk), .wb_rst(wb_rst),
       .stb_i(setting_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
       .ack_o(setting_ack),
       .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   for (genvar i = 0; i < NUM_SETTINGS; i++)
   begin : g_setting
      setting_reg #(.MY_ADDR(i)) setting_reg_i
         (.wb_clk(wb_clk), .wb_rst(wb_rst),
          .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
          .value_o(setting_words[i]), .changed_o(setting_changed_o[i]));
   end

   //////////////////////////////////////////////////////////////////////
   // slave 7, setting readback

   readback_mux_16 #(.NUM_SETTINGS(NUM_SETTINGS)) readback_mux_16_i
      (.wb_clk(wb_clk), .wb_rst(wb_rst),
       .stb_i(rb_stb), .adr_i(wb_adr_i[5:0]), .words_i(setting_words),
       .dat_o(rb_dat), .ack_o(rb_ack));

endmodule

/* verilog/readback_mux_16.sv */
module readback_mux_16
   #(parameter int NUM_SETTINGS = 8)
   (input  logic                                     wb_clk,
    input  logic                                     wb_rst,
    input  logic                                     stb_i,
    input  logic [5:0]                               adr_i,
    input  u1_ctrl_pkg::set_data_t [NUM_SETTINGS-1:0] words_i,
    output u1_ctrl_pkg::wb_data_t                    dat_o,
    output logic                                     ack_o);

   import u1_ctrl_pkg::*;

   logic [3:0] word_idx;
   set_data_t  word;
   wb_data_t   half;

   assign word_idx = adr_i[5:2];

   // indices past the last setting read zero
   always_comb
   begin
      word = '0;
      if (int'(word_idx) < NUM_SETTINGS)
         word = words_i[word_idx];
   end

   assign half = adr_i[1] ? word[31:16] : word[15:0];   // bit 1 picks the half

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;   // one cycle, never back to back
   end

   always_ff @(posedge wb_clk)
   begin
      if (stb_i)
         dat_o <= half;
   end

endmodule

/* verilog/setting_reg.sv */
module setting_reg
   #(parameter int MY_ADDR = 0)
   (input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  logic                   set_stb_i,
    input  u1_ctrl_pkg::set_addr_t set_addr_i,
    input  u1_ctrl_pkg::set_data_t set_data_i,
    output u1_ctrl_pkg::set_data_t value_o,
    output logic                   changed_o);

   import u1_ctrl_pkg::*;

   logic hit;

   assign hit = set_stb_i && (set_addr_i == set_addr_t'(MY_ADDR));

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         value_o   <= '0;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit;   // single cycle, strobe lasts one cycle
         if (hit)
            value_o <= set_data_i;
      end
   end

endmodule

/* verilog/settings_bus_16.sv */
module settings_bus_16
   (input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  u1_ctrl_pkg::wb_addr_t  adr_i,
    input  u1_ctrl_pkg::wb_data_t  dat_i,
    output logic                   ack_o,
    output logic                   set_stb_o,
    output u1_ctrl_pkg::set_addr_t set_addr_o,
    output u1_ctrl_pkg::set_data_t set_data_o);

   import u1_ctrl_pkg::*;

   wb_data_t lo_half;   // low half waits here for its high half
   logic     wr;

   assign ack_o = stb_i;   // no wait states, reads included
   assign wr    = stb_i & we_i;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         lo_half    <= '0;
         set_stb_o  <= 1'b0;
         set_addr_o <= '0;
         set_data_o <= '0;
      end
      else
      begin
         set_stb_o <= wr & adr_i[1];   // one cycle per high half write
         if (wr && !adr_i[1])
            lo_half <= dat_i;
         if (wr && adr_i[1])
         begin
            set_addr_o <= {2'b00, adr_i[7:2]};
            set_data_o <= {dat_i, lo_half};
         end
      end
   end

endmodule

/* verilog/misc_ctrl_regs.sv */
module misc_ctrl_regs
   (input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  u1_ctrl_pkg::reg_offs_t adr_i,
    input  u1_ctrl_pkg::wb_data_t  dat_i,
    output u1_ctrl_pkg::wb_data_t  dat_o,
    output logic                   ack_o,
    input  logic                   cgen_st_status_i,
    input  logic                   cgen_st_ld_i,
    input  logic                   cgen_st_refmon_i,
    output logic [2:0]             led_o,
    output logic                   cgen_sync_b_o,
    output logic                   cgen_ref_sel_o,
    output logic [7:0]             frames_per_packet_o,
    output logic [15:0]            test_len_o,
    output logic [7:0]             test_rate_o,
    output logic [3:0]             test_ctrl_o);

   import u1_ctrl_pkg::*;

   logic [2:0]  reg_leds;
   logic [1:0]  reg_cgen_ctrl;   // {sync_b, ref_sel}
   wb_data_t    reg_test;
   logic [11:0] xfer_rate;       // {ctrl, rate}
   logic [7:0]  frames_per_packet;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds          <= '0;
         reg_cgen_ctrl     <= 2'b11;   // sync_b released, external ref
         reg_test          <= '0;
         xfer_rate         <= '0;
         frames_per_packet <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i)
            REG_LEDS        : reg_leds          <= dat_i[2:0];
            REG_CGEN_CTRL   : reg_cgen_ctrl     <= dat_i[1:0];
            REG_TEST        : reg_test          <= dat_i;
            REG_RX_FRAMELEN : frames_per_packet <= dat_i[7:0];
            REG_XFER_RATE   : xfer_rate         <= dat_i[11:0];
            default         : ;
         endcase
      end
   end

   // board LEDs are not wired in bit order
   assign {led_o[2], led_o[0], led_o[1]} = reg_leds;
   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl;
   assign test_ctrl_o         = xfer_rate[11:8];
   assign test_rate_o         = xfer_rate[7:0];
   assign test_len_o          = reg_test;
   assign frames_per_packet_o = frames_per_packet;

   always_comb
   begin
      case (adr_i)
         REG_LEDS      : dat_o = {13'd0, reg_leds};
         REG_CGEN_CTRL : dat_o = {14'd0, reg_cgen_ctrl};
         REG_CGEN_ST   : dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST      : dat_o = reg_test;
         REG_COMPAT    : dat_o = COMPAT_NUM;
         default       : dat_o = UNMAPPED_READ;
      endcase
   end

   assign ack_o = stb_i;   // no wait states

endmodule

/* verilog/wb_addr_decode.sv */
module wb_addr_decode
   (input  u1_ctrl_pkg::wb_addr_t wb_adr_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  misc_ack_i,
    input  u1_ctrl_pkg::wb_data_t misc_dat_i,
    input  logic                  setting_ack_i,
    input  logic                  rb_ack_i,
    input  u1_ctrl_pkg::wb_data_t rb_dat_i,
    output logic                  misc_stb_o,
    output logic                  setting_stb_o,
    output logic                  rb_stb_o,
    output logic                  wb_ack_o,
    output u1_ctrl_pkg::wb_data_t wb_dat_o);

   import u1_ctrl_pkg::*;

   region_t region;
   logic    bus_req;
   logic    misc_sel, setting_sel, rb_sel;

   assign region  = wb_adr_i[WB_ADDR_W-1 -: REGION_W];
   assign bus_req = wb_cyc_i & wb_stb_i;

   // settings slave is double wide, lowest region bit ignored
   assign misc_sel    = (region == REGION_MISC);
   assign rb_sel      = (region == REGION_READBACK);
   assign setting_sel = (region[REGION_W-1:1] == REGION_SETTINGS[REGION_W-1:1]);

   assign misc_stb_o    = bus_req & misc_sel;
   assign setting_stb_o = bus_req & setting_sel;
   assign rb_stb_o      = bus_req & rb_sel;

   //////////////////////////////////////////////////////////////////////
   // return path, muxed by region

   always_comb
   begin
      wb_ack_o = 1'b0;   // unmapped regions never ack
      wb_dat_o = '0;
      if (misc_sel)
      begin
         wb_ack_o = misc_ack_i;
         wb_dat_o = misc_dat_i;
      end
      else if (rb_sel)
      begin
         wb_ack_o = rb_ack_i;
         wb_dat_o = rb_dat_i;
      end
      else if (setting_sel)
      begin
         wb_ack_o = setting_ack_i;   // settings reads return zero
      end
   end

endmodule

/* verilog/u1_ctrl_pkg.sv */
package u1_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // bus widths and word types

   localparam int WB_DATA_W = 16;
   localparam int WB_ADDR_W = 11;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef logic [WB_DATA_W-1:0]  wb_data_t;   // host bus data word
   typedef logic [WB_ADDR_W-1:0]  wb_addr_t;   // host bus byte address
   typedef logic [SET_ADDR_W-1:0] set_addr_t;  // settings register index
   typedef logic [SET_DATA_W-1:0] set_data_t;  // settings word

   //////////////////////////////////////////////////////////////////////
   // slave regions, picked by the top address bits

   localparam int REGION_W = 4;   // 128 bytes per region

   typedef logic [REGION_W-1:0] region_t;
   typedef logic [WB_ADDR_W-REGION_W-1:0] reg_offs_t;   // offset inside a region

   localparam region_t REGION_MISC     = 4'd0;
   localparam region_t REGION_READBACK = 4'd7;
   localparam region_t REGION_SETTINGS = 4'd8;   // also answers region 9

   //////////////////////////////////////////////////////////////////////
   // misc control register byte offsets

   localparam reg_offs_t REG_LEDS        = 7'd0;
   localparam reg_offs_t REG_CGEN_CTRL   = 7'd4;
   localparam reg_offs_t REG_CGEN_ST     = 7'd6;    // read only
   localparam reg_offs_t REG_TEST        = 7'd8;
   localparam reg_offs_t REG_RX_FRAMELEN = 7'd10;   // write only
   localparam reg_offs_t REG_XFER_RATE   = 7'd14;   // write only
   localparam reg_offs_t REG_COMPAT      = 7'd16;   // read only

   // fixed read values
   localparam wb_data_t COMPAT_NUM    = 16'h0004;
   localparam wb_data_t UNMAPPED_READ = 16'hBEEF;

endpackage
